//--- common/alu_pkg.sv
`default_nettype none

package alu_pkg;

    ////////////////////////////////////////////////////////////
    // widths

    localparam int data_w = 32;
    localparam int func_w = 3;
    localparam int addr_w = 8;   // apb byte address

    ////////////////////////////////////////////////////////////
    // function codes

    localparam logic [func_w-1:0] func_add    = 3'd0;
    localparam logic [func_w-1:0] func_sub    = 3'd1;
    localparam logic [func_w-1:0] func_and    = 3'd2;
    localparam logic [func_w-1:0] func_pass_a = 3'd3;
    localparam logic [func_w-1:0] func_or     = 3'd4;
    localparam logic [func_w-1:0] func_not_a  = 3'd5;
    localparam logic [func_w-1:0] func_xnor   = 3'd6;
    localparam logic [func_w-1:0] func_not_b  = 3'd7;

    ////////////////////////////////////////////////////////////
    // register map

    localparam logic [addr_w-1:0] addr_opa    = 8'h00;   // rw
    localparam logic [addr_w-1:0] addr_opb    = 8'h04;   // rw
    localparam logic [addr_w-1:0] addr_func   = 8'h08;   // rw, bits 2:0
    localparam logic [addr_w-1:0] addr_result = 8'h0C;   // ro, one wait state
    localparam logic [addr_w-1:0] addr_status = 8'h10;   // ro, one wait state

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [addr_w-1:0] paddr;
        logic [data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // zero lands in bit 0 of the status word
    typedef struct packed {
        logic borrow;
        logic carry;
        logic zero;
    } alu_flags_t;

endpackage

`default_nettype wire

//--- alu/ripple_adder.sv
`timescale 1ns/1ps
`default_nettype none

module ripple_adder (
    input  logic [alu_pkg::data_w-1:0] a,
    input  logic [alu_pkg::data_w-1:0] b,
    output wire  [alu_pkg::data_w-1:0] sum,
    output logic                       carry
);

    wire [alu_pkg::data_w:0] c;   // c[i] is the carry into bit i

    assign c[0] = 1'b0;   // no carry-in

    ////////////////////////////////////////////////////////////
    // full-adder chain, two half adders and an or per bit

    for (genvar i = 0; i < alu_pkg::data_w; i++) begin : g_fa
        wire s1;
        wire c1;
        wire c2;

        // first half adder on the operand bits
        xor (s1, a[i], b[i]);
        and (c1, a[i], b[i]);

        // second half adder folds in the incoming carry
        xor (sum[i], s1, c[i]);
        and (c2, s1, c[i]);

        or  (c[i+1], c1, c2);
    end

    assign carry = c[alu_pkg::data_w];

endmodule

`default_nettype wire

//--- alu/ripple_subtractor.sv
`timescale 1ns/1ps
`default_nettype none

module ripple_subtractor (
    input  logic [alu_pkg::data_w-1:0] a,
    input  logic [alu_pkg::data_w-1:0] b,
    output wire  [alu_pkg::data_w-1:0] diff,
    output logic                       borrow
);

    wire [alu_pkg::data_w:0] bw;   // bw[i] is the borrow into bit i

    assign bw[0] = 1'b0;

    ////////////////////////////////////////////////////////////
    // full-subtractor chain, a minus b

    for (genvar i = 0; i < alu_pkg::data_w; i++) begin : g_fs
        wire d1;
        wire na;
        wire nd1;
        wire b1;
        wire b2;

        // a - b for this bit
        xor (d1, a[i], b[i]);
        not (na, a[i]);
        and (b1, na, b[i]);

        // then take away the borrow from below
        xor (diff[i], d1, bw[i]);
        not (nd1, d1);
        and (b2, nd1, bw[i]);

        or  (bw[i+1], b1, b2);
    end

    // set when b > a unsigned
    assign borrow = bw[alu_pkg::data_w];

endmodule

`default_nettype wire

//--- alu/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  logic [alu_pkg::data_w-1:0] opa,
    input  logic [alu_pkg::data_w-1:0] opb,
    input  logic [alu_pkg::func_w-1:0] func,
    output logic [alu_pkg::data_w-1:0] result,
    output alu_pkg::alu_flags_t        flags
);

    logic [alu_pkg::data_w-1:0] sum_res;
    logic [alu_pkg::data_w-1:0] diff_res;
    logic [alu_pkg::data_w-1:0] and_res;
    logic [alu_pkg::data_w-1:0] or_res;
    logic [alu_pkg::data_w-1:0] xnor_res;
    logic [alu_pkg::data_w-1:0] not_a_res;
    logic [alu_pkg::data_w-1:0] not_b_res;
    logic [alu_pkg::data_w-1:0] pass_a_res;
    logic                       add_carry;
    logic                       sub_borrow;

    logic sel_add, sel_sub, sel_and, sel_pass_a;
    logic sel_or, sel_not_a, sel_xnor, sel_not_b;

    ripple_adder u_ripple_adder (
        .a     (opa),
        .b     (opb),
        .sum   (sum_res),
        .carry (add_carry)
    );

    ripple_subtractor u_ripple_subtractor (
        .a      (opa),
        .b      (opb),
        .diff   (diff_res),
        .borrow (sub_borrow)
    );

    ////////////////////////////////////////////////////////////
    // bitwise functions

    assign and_res    = opa & opb;
    assign or_res     = opa | opb;
    assign xnor_res   = ~(opa ^ opb);
    assign not_a_res  = ~opa;
    assign not_b_res  = ~opb;
    assign pass_a_res = opa;

    // one-hot decode of the function code
    assign sel_add    = (func == alu_pkg::func_add);
    assign sel_sub    = (func == alu_pkg::func_sub);
    assign sel_and    = (func == alu_pkg::func_and);
    assign sel_pass_a = (func == alu_pkg::func_pass_a);
    assign sel_or     = (func == alu_pkg::func_or);
    assign sel_not_a  = (func == alu_pkg::func_not_a);
    assign sel_xnor   = (func == alu_pkg::func_xnor);
    assign sel_not_b  = (func == alu_pkg::func_not_b);

    // and-or select, exactly one term is live
    assign result = ({alu_pkg::data_w{sel_add}}    & sum_res)    |
                    ({alu_pkg::data_w{sel_sub}}    & diff_res)   |
                    ({alu_pkg::data_w{sel_and}}    & and_res)    |
                    ({alu_pkg::data_w{sel_pass_a}} & pass_a_res) |
                    ({alu_pkg::data_w{sel_or}}     & or_res)     |
                    ({alu_pkg::data_w{sel_not_a}}  & not_a_res)  |
                    ({alu_pkg::data_w{sel_xnor}}   & xnor_res)   |
                    ({alu_pkg::data_w{sel_not_b}}  & not_b_res);

    // carry and borrow follow the operands, not the selected function
    assign flags = '{
        borrow: sub_borrow,
        carry:  add_carry,
        zero:   ~|result
    };

endmodule

`default_nettype wire

//--- design/alu_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module alu_apb_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  alu_pkg::apb_req_t          req,
    output alu_pkg::apb_rsp_t          rsp,
    output logic [alu_pkg::data_w-1:0] opa,
    output logic [alu_pkg::data_w-1:0] opb,
    output logic [alu_pkg::func_w-1:0] func,
    input  logic [alu_pkg::data_w-1:0] result,
    input  alu_pkg::alu_flags_t        flags
);

    typedef struct packed {
        alu_pkg::alu_flags_t        flags;
        logic [alu_pkg::data_w-1:0] result;
    } capture_t;

    logic access;        // access phase of a transfer
    logic hit_opa;
    logic hit_opb;
    logic hit_func;
    logic hit_result;
    logic hit_status;
    logic mapped;
    logic writable;
    logic err;
    logic wr_en;
    logic slow;          // result or status read
    logic wait_q;        // first access cycle of a slow read done
    capture_t capture_q;
    logic [alu_pkg::data_w-1:0] rd_data;

    ////////////////////////////////////////////////////////////
    // address decode

    assign access     = req.psel & req.penable;
    assign hit_opa    = (req.paddr == alu_pkg::addr_opa);
    assign hit_opb    = (req.paddr == alu_pkg::addr_opb);
    assign hit_func   = (req.paddr == alu_pkg::addr_func);
    assign hit_result = (req.paddr == alu_pkg::addr_result);
    assign hit_status = (req.paddr == alu_pkg::addr_status);

    assign writable = hit_opa | hit_opb | hit_func;
    assign mapped   = writable | hit_result | hit_status;
    assign err      = ~mapped | (req.pwrite & ~writable);   // unmapped, or write to ro
    assign wr_en    = access & req.pwrite & writable;
    assign slow     = access & ~req.pwrite & (hit_result | hit_status);

    ////////////////////////////////////////////////////////////
    // registers

    always_ff @(posedge clk) begin
        if (rst) begin
            opa       <= '0;
            opb       <= '0;
            func      <= '0;
            wait_q    <= 1'b0;
            capture_q <= '0;
        end else begin
            if (wr_en & hit_opa) begin
                opa <= req.pwdata;
            end
            if (wr_en & hit_opb) begin
                opb <= req.pwdata;
            end
            if (wr_en & hit_func) begin
                func <= req.pwdata[alu_pkg::func_w-1:0];
            end

            // one wait state, then complete
            wait_q <= slow & ~wait_q;

            // sample the ripple path at the end of the wait state
            if (slow & ~wait_q) begin
                capture_q <= '{flags: flags, result: result};
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read side

    always_comb begin
        case (req.paddr)
            alu_pkg::addr_opa:    rd_data = opa;
            alu_pkg::addr_opb:    rd_data = opb;
            alu_pkg::addr_func: begin
                rd_data = {{(alu_pkg::data_w - alu_pkg::func_w){1'b0}}, func};
            end
            alu_pkg::addr_result: rd_data = capture_q.result;
            alu_pkg::addr_status: begin
                rd_data = {{(alu_pkg::data_w - $bits(alu_pkg::alu_flags_t)){1'b0}},
                           capture_q.flags};
            end
            default:              rd_data = '0;   // unmapped reads zero
        endcase
    end

    always_comb begin
        rsp.prdata  = rd_data;
        rsp.pready  = access & (~slow | wait_q);
        rsp.pslverr = access & err;   // err never pairs with slow
    end

endmodule

`default_nettype wire

//--- design/alu_apb_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_apb_top (
    input  logic              clk,
    input  logic              rst,
    input  alu_pkg::apb_req_t req,
    output alu_pkg::apb_rsp_t rsp
);

    logic [alu_pkg::data_w-1:0] opa;
    logic [alu_pkg::data_w-1:0] opb;
    logic [alu_pkg::func_w-1:0] func;
    logic [alu_pkg::data_w-1:0] result;
    alu_pkg::alu_flags_t        flags;

    // bus side, operand registers and capture stage
    alu_apb_regs u_alu_apb_regs (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rsp    (rsp),
        .opa    (opa),
        .opb    (opb),
        .func   (func),
        .result (result),
        .flags  (flags)
    );

    alu_core u_alu_core (
        .opa    (opa),
        .opb    (opb),
        .func   (func),
        .result (result),
        .flags  (flags)
    );

endmodule

`default_nettype wire

//--- test/alu_props.sv
`timescale 1ns/1ps
`default_nettype none

module alu_props (
    input  logic              clk,
    input  logic              rst,
    input  alu_pkg::apb_req_t req,
    input  alu_pkg::apb_rsp_t rsp
);

    int   fails = 0;     // read by the testbench at the end of the run
    logic slow_setup;

    assign slow_setup = req.psel & ~req.penable & ~req.pwrite &
                        ((req.paddr == alu_pkg::addr_result) |
                         (req.paddr == alu_pkg::addr_status));

    ////////////////////////////////////////////////////////////
    // apb protocol

    // request held until the access completes
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req.psel && !(req.penable && rsp.pready)
        |=> req.psel && $stable({req.pwrite, req.paddr, req.pwdata}))
        else begin
            $error("apb request changed before the transfer completed");
            fails++;
        end

    a_setup_then_enable: assert property (@(posedge clk) disable iff (rst)
        req.psel && !req.penable |=> req.penable)
        else begin
            $error("penable did not follow the setup cycle");
            fails++;
        end

    a_err_with_ready: assert property (@(posedge clk) disable iff (rst)
        rsp.pslverr |-> rsp.pready)
        else begin
            $error("pslverr high without pready");
            fails++;
        end

    // result and status reads stall in their first access cycle
    a_wait_state: assert property (@(posedge clk) disable iff (rst)
        slow_setup |=> !rsp.pready)
        else begin
            $error("result or status read skipped its wait state");
            fails++;
        end

endmodule

bind alu_apb_regs alu_props u_alu_props (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
);

`default_nettype wire

//--- test/alu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module alu_checker (
    input  logic              clk,
    input  logic              rst,
    input  alu_pkg::apb_req_t req,
    input  alu_pkg::apb_rsp_t rsp,
    output int                errors,
    output int                checks
);

    logic [31:0] exp_res[$];     // file expectations in read order
    logic [31:0] exp_stat[$];
    logic [31:0] m_opa;
    logic [31:0] m_opb;
    logic [2:0]  m_func;
    int          cyc;            // cycles since setup
    int          res_idx;
    int          stat_idx;
    int          load_errors = 0;
    int          cmp_errors = 0;
    int          n_checks = 0;

    assign errors = load_errors + cmp_errors;
    assign checks = n_checks;

    initial begin : load_expected
        int          fd;
        int          rc;
        string       line;
        logic [31:0] a, b, f, r, s;
        fd = $fopen("test/alu_input.txt", "r");
        if (fd == 0) begin
            load_errors++;
            $display("checker could not open test/alu_input.txt");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && $sscanf(line, "%h %h %h %h %h", a, b, f, r, s) == 5) begin
                    exp_res.push_back(r);
                    exp_stat.push_back(s);
                end
            end
            $fclose(fd);
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] model_result(input logic [31:0] a, input logic [31:0] b,
                                                 input logic [2:0] f);
        case (f)
            alu_pkg::func_add:    return a + b;
            alu_pkg::func_sub:    return a - b;
            alu_pkg::func_and:    return a & b;
            alu_pkg::func_pass_a: return a;
            alu_pkg::func_or:     return a | b;
            alu_pkg::func_not_a:  return ~a;
            alu_pkg::func_xnor:   return ~(a ^ b);
            alu_pkg::func_not_b:  return ~b;
            default:              return 32'h0;
        endcase
    endfunction

    // borrow, carry, zero from bit 2 down
    function automatic logic [31:0] model_status(input logic [31:0] a, input logic [31:0] b,
                                                 input logic [2:0] f);
        logic [32:0] full_sum;
        full_sum = {1'b0, a} + {1'b0, b};
        return {29'b0, (b > a), full_sum[32], (model_result(a, b, f) == 32'h0)};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            cmp_errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_transfer();
        logic [7:0]  addr;
        logic        writable;
        logic        read_only;
        logic        slow;
        logic        exp_err;
        logic [31:0] exp_data;
        addr      = req.paddr;
        writable  = (addr == alu_pkg::addr_opa) || (addr == alu_pkg::addr_opb) ||
                    (addr == alu_pkg::addr_func);
        read_only = (addr == alu_pkg::addr_result) || (addr == alu_pkg::addr_status);
        slow      = read_only && !req.pwrite;
        exp_err   = !(writable || read_only) || (req.pwrite && !writable);
        if (cyc != (slow ? 3 : 2)) begin
            cmp_errors++;
            $display("transfer at 0x%02h lasted %0d cycles instead of %0d",
                     addr, cyc, slow ? 3 : 2);
        end
        compare_value($sformatf("pslverr @0x%02h", addr), {31'b0, rsp.pslverr}, {31'b0, exp_err});
        if (req.pwrite) begin
            case (addr)   // read-only and unmapped writes fall through
                alu_pkg::addr_opa:  m_opa = req.pwdata;
                alu_pkg::addr_opb:  m_opb = req.pwdata;
                alu_pkg::addr_func: m_func = req.pwdata[2:0];
                default:            ;
            endcase
        end else begin
            case (addr)
                alu_pkg::addr_opa:  exp_data = m_opa;
                alu_pkg::addr_opb:  exp_data = m_opb;
                alu_pkg::addr_func: exp_data = {29'b0, m_func};
                alu_pkg::addr_result: begin
                    exp_data = model_result(m_opa, m_opb, m_func);
                    if (res_idx < exp_res.size()) begin
                        compare_value($sformatf("prdata file result %0d", res_idx),
                                      rsp.prdata, exp_res[res_idx]);
                    end
                    res_idx++;
                end
                alu_pkg::addr_status: begin
                    exp_data = model_status(m_opa, m_opb, m_func);
                    if (stat_idx < exp_stat.size()) begin
                        compare_value($sformatf("prdata file status %0d", stat_idx),
                                      rsp.prdata, exp_stat[stat_idx]);
                    end
                    stat_idx++;
                end
                default: exp_data = 32'h0;
            endcase
            compare_value($sformatf("prdata @0x%02h", addr), rsp.prdata, exp_data);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus monitor

    always @(posedge clk) begin
        if (rst) begin
            m_opa    = 32'h0;
            m_opb    = 32'h0;
            m_func   = 3'h0;
            cyc      = 0;
            res_idx  = 0;
            stat_idx = 0;
        end else if (req.psel && req.penable) begin
            cyc = cyc + 1;
            if (rsp.pready) begin
                check_transfer();
            end
        end else begin
            cyc = req.psel ? 1 : 0;   // setup or idle
            compare_value("pready outside access", {31'b0, rsp.pready}, 32'h0);
            compare_value("pslverr outside access", {31'b0, rsp.pslverr}, 32'h0);
        end
    end

endmodule

`default_nettype wire

//--- test/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb;

    localparam int n_rand = 64;
    localparam int cycles_per_vec = 20;

    logic              clk = 1'b0;
    logic              rst;
    alu_pkg::apb_req_t req;
    alu_pkg::apb_rsp_t rsp;
    int                chk_errors;
    int                chk_checks;
    int                tb_errors = 0;
    int                timeouts = 0;
    int                cycles = 0;
    int                limit;
    logic [31:0]       vec_a[$];
    logic [31:0]       vec_b[$];
    logic [31:0]       vec_f[$];

    alu_apb_top u_alu_apb_top (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    alu_checker u_alu_checker (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rsp    (rsp),
        .errors (chk_errors),
        .checks (chk_checks)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // tasks

    task automatic report_counts();
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d, tb errors %0d",
                 chk_checks, chk_errors, u_alu_apb_top.u_alu_apb_regs.u_alu_props.fails,
                 timeouts, tb_errors);
    endtask

    task automatic load_vectors();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] a, b, f, r, s;
        fd = $fopen("test/alu_input.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("could not open test/alu_input.txt");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && $sscanf(line, "%h %h %h %h %h", a, b, f, r, s) == 5) begin
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_f.push_back(f);
                end
            end
            $fclose(fd);
            if (vec_a.size() == 0) begin
                tb_errors++;
                $display("test/alu_input.txt holds no vectors");
            end
        end
    endtask

    // setup on one falling edge, access on the next, then wait for pready
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data);
        @(negedge clk);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = data;
        @(negedge clk);
        req.penable = 1'b1;
        @(posedge clk);
        while (!rsp.pready) begin
            @(posedge clk);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        apb_transfer(1'b1, addr, data);
    endtask

    task automatic read_reg(input logic [7:0] addr);
        apb_transfer(1'b0, addr, 32'h0);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        rnd = $urandom(83);
        rst = 1'b1;
        req = '0;
        load_vectors();
        limit = (vec_a.size() + n_rand) * cycles_per_vec + 100;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_reg(alu_pkg::addr_opa);   // all zero out of reset
        read_reg(alu_pkg::addr_opb);
        read_reg(alu_pkg::addr_func);

        for (int i = 0; i < vec_a.size(); i++) begin
            write_reg(alu_pkg::addr_opa, vec_a[i]);
            write_reg(alu_pkg::addr_opb, vec_b[i]);
            write_reg(alu_pkg::addr_func, vec_f[i]);
            read_reg(alu_pkg::addr_opa);
            read_reg(alu_pkg::addr_opb);
            read_reg(alu_pkg::addr_func);
            read_reg(alu_pkg::addr_result);
            read_reg(alu_pkg::addr_status);
        end

        for (int i = 0; i < n_rand; i++) begin
            a   = $urandom();
            b   = $urandom();
            rnd = $urandom();
            if (rnd[4:3] == 2'b00) begin
                b = a;      // equal operands
            end else if (rnd[4:3] == 2'b01) begin
                b = ~a;     // sum of all ones
            end
            write_reg(alu_pkg::addr_opa, a);
            write_reg(alu_pkg::addr_opb, b);
            write_reg(alu_pkg::addr_func, rnd);   // upper bits are junk
            read_reg(alu_pkg::addr_func);
            read_reg(alu_pkg::addr_result);
            read_reg(alu_pkg::addr_status);
        end

        // illegal accesses leave every register as it was
        write_reg(alu_pkg::addr_result, 32'h1111_1111);
        write_reg(alu_pkg::addr_status, 32'h2222_2222);
        write_reg(8'h14, 32'h3333_3333);
        write_reg(8'h02, 32'h4444_4444);
        read_reg(8'h14);
        read_reg(8'hfc);
        read_reg(alu_pkg::addr_opa);
        read_reg(alu_pkg::addr_opb);
        read_reg(alu_pkg::addr_func);
        read_reg(alu_pkg::addr_result);
        read_reg(alu_pkg::addr_status);

        @(negedge clk);
        req = '0;
        repeat (2) @(posedge clk);
        report_counts();
        if (chk_errors + tb_errors + u_alu_apb_top.u_alu_apb_regs.u_alu_props.fails == 0
            && chk_checks > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            timeouts++;
            $display("timeout, the run did not finish within %0d cycles", limit);
            report_counts();
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- test/alu_input.txt
// columns in hex: operand A, operand B, function code, expected result,
// expected status (bit 2 borrow, bit 1 carry, bit 0 zero)
00000005 00000003 0 00000008 0
FFFFFFFF 00000001 0 00000000 3
80000000 80000000 0 00000000 3
12345678 11111111 0 23456789 0
00000003 00000005 1 FFFFFFFE 4
00000010 00000010 1 00000000 1
00000000 00000001 1 FFFFFFFF 4
DEADBEEF 00000001 1 DEADBEEE 0
F0F0F0F0 FF00FF00 2 F000F000 6
0F0F0F0F F0F0F0F0 2 00000000 5
CAFEBABE 00000000 3 CAFEBABE 0
00000000 FFFFFFFF 3 00000000 5
00FF00FF 0F0F0F0F 4 0FFF0FFF 4
00000000 00000000 4 00000000 1
00000000 12345678 5 FFFFFFFF 4
FFFFFFFF 00000001 5 00000000 3
AAAAAAAA AAAAAAAA 6 FFFFFFFF 2
AAAAAAAA 55555555 6 00000000 1
12345678 0000FFFF 6 EDCB5678 0
00000001 FFFFFFFF 7 00000000 7
7FFFFFFF 00000001 7 FFFFFFFE 0
80000000 00000001 1 7FFFFFFF 0
00000001 80000000 0 80000001 4
FFFFFFFF FFFFFFFF 0 FFFFFFFE 2

//--- sources.f
common/alu_pkg.sv
alu/ripple_adder.sv
alu/ripple_subtractor.sv
alu/alu_core.sv
design/alu_apb_regs.sv
design/alu_apb_top.sv
test/alu_props.sv
test/alu_checker.sv
test/alu_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := alu_tb
RTL_TOP    := alu_apb_top
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
SIM_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
